/* test/tcb_input_vectors.txt */
// test op(0 read 1 write) address wdata ben expected_rdata expected_err check_rdata
// all hex except the test number, check_rdata 0 leaves the read data unchecked
1  1 010 11223344 f 00000000 0 0
1  0 010 00000000 0 11223344 0 1
1  1 010 aabbccdd 5 11223344 0 1
1  0 010 00000000 0 11bb33dd 0 1
1  1 3fc cafef00d f 00000000 0 0
1  0 3fc 00000000 0 cafef00d 0 1
2  0 800 00000000 0 7cb00001 0 1
2  1 800 ffffffff f 00000000 1 0
2  0 800 00000000 0 7cb00001 0 1
3  1 804 12345678 f 00000000 0 0
3  0 804 00000000 0 12345678 0 1
3  1 804 9abcdef0 6 00000000 0 0
3  0 804 00000000 0 12bcde78 0 1
4  1 808 00000055 f 00000000 1 0
4  0 80c 00000000 0 00000000 1 0
4  1 804 a5a5a5a5 3 00000000 0 0
4  0 808 00000000 0 00000003 0 1
4  0 804 00000000 0 12bca5a5 0 1
5  0 400 00000000 0 00000000 1 1
5  1 c00 deadbeef f 00000000 1 1
5  0 810 00000000 0 00000000 1 1
6  1 804 00000001 f 00000000 0 0
6  1 020 77777777 f 00000000 0 0
6  1 804 00000002 f 00000000 0 0
6  0 804 00000000 0 00000002 0 1
6  0 020 00000000 0 77777777 0 1
6  0 808 00000000 0 00000005 0 1
6  0 400 00000000 0 00000000 1 1

/* tb.f */
logic/tcb_pkg.sv
logic/tcb_register_request.sv
logic/tcb_address_demux.sv
logic/tcb_sram.sv
logic/tcb_status_regs.sv
logic/tcb_response_mux.sv
logic/tcb_subsystem.sv
test/tcb_clock_gen.sv
test/tcb_subsystem_tb.sv

/* run.sh */
#!/bin/sh
# build the subsystem and its testbench with verilator and run it
# the result is taken from the simulation log

verilator --binary --timing --assert --top-module tcb_subsystem_tb -f tb.f -o tcb_sim \
  || { echo "verilator build failed"; exit 1; }

./obj_dir/tcb_sim > sim.log 2>&1 || echo "simulator returned an error status"
cat sim.log

grep -q "STATUS: FAIL" sim.log && { echo "simulation failed"; exit 1; }
grep -q "STATUS: PASS" sim.log || { echo "no pass status in the log"; exit 1; }
echo "simulation passed"

/* test/tcb_subsystem_tb.sv */
// testbench for the bus subsystem
// reads accesses and their expected responses from the vector file,
// drives them on the falling edge with random idle gaps, and checks
// every response, its data and its cycle, in request order against a
// queue of expected values
// a watchdog ends the run if responses stop arriving

`timescale 1ns/1ps

module tcb_subsystem_tb import tcb_pkg::*; ();

  // watchdog budget per access
  localparam int cycles_per_vec = 10;
  // accesses of this test are issued with no idle gap
  localparam int back_to_back_test = 6;
  // register block spans four words from its base
  localparam int regs_bytes = 16;

  // one access with its expected response
  typedef struct packed {
    logic [7:0]       num;
    logic [15:0]      idx;
    tcb_req_t         req;
    logic [dat_w-1:0] exp_rdt;
    logic             exp_err;
    // read data is compared only when set
    logic             chk;
    // clock edge at which the response is due
    logic [31:0]      due;
  } vec_t;

  logic     sub;
  logic     rst_n;
  logic     req_vld;
  tcb_req_t req;
  logic     req_rdy;
  logic     rsp_vld;
  tcb_rsp_t rsp;

  vec_t vecs[$];
  vec_t exp_q[$];
  vec_t drv_vec;
  int   n_checks;
  int   n_errors;
  int   n_rsp;
  int   tests_run;
  int   tests_failed;
  int   test_errs;
  // rising edge count and the edge of the last register block write
  int   cyc;
  int   regs_wr_edge;

  tcb_clock_gen clock_gen_i (
    .sub   (sub),
    .rst_n (rst_n)
  );

  tcb_subsystem tcb_subsystem_i (
    .sub     (sub),
    .rst_n   (rst_n),
    .req_vld (req_vld),
    .req     (req),
    .req_rdy (req_rdy),
    .rsp_vld (rsp_vld),
    .rsp     (rsp)
  );

  //////////////////////////////////////////////////
  // vector file
  //////////////////////////////////////////////////

  task automatic load_vectors();
    int          fd;
    string       line;
    vec_t        v;
    int          num;
    logic [31:0] op;
    logic [31:0] adr;
    logic [31:0] wdt;
    logic [31:0] ben;
    logic [31:0] rdt;
    logic [31:0] err;
    logic [31:0] chk;
    fd = $fopen("test/tcb_input_vectors.txt", "r");
    if (fd == 0) begin
      $display("the vector file test/tcb_input_vectors.txt could not be opened");
      n_errors++;
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      // comment and blank lines fail the scan and are skipped
      if ($sscanf(line, "%d %h %h %h %h %h %h %h",
                  num, op, adr, wdt, ben, rdt, err, chk) == 8) begin
        v.num     = num[7:0];
        v.idx     = 16'(vecs.size());
        v.req.op  = tcb_op_e'(op[0]);
        v.req.adr = adr[adr_w-1:0];
        v.req.wdt = wdt;
        v.req.ben = ben[ben_w-1:0];
        v.exp_rdt = rdt;
        v.exp_err = err[0];
        v.chk     = chk[0];
        v.due     = '0;
        vecs.push_back(v);
      end
    end
    $fclose(fd);
    if (vecs.size() == 0) begin
      $display("the vector file holds no accesses");
      n_errors++;
    end
  endtask

  //////////////////////////////////////////////////
  // driver
  //////////////////////////////////////////////////

  // called on a falling edge, returns on the falling edge after the
  // transfer with valid still high
  task automatic drive_request(input vec_t v);
    drv_vec = v;
    req     = v.req;
    req_vld = 1'b1;
    // ready does not depend on the request just driven
    while (!req_rdy) @(negedge sub);
    @(negedge sub);
  endtask

  //////////////////////////////////////////////////
  // monitor and checks
  //////////////////////////////////////////////////

  // queue the access taken at this edge with the edge of its response
  function automatic void push_expected();
    vec_t e;
    int   dep;
    logic to_regs;
    e       = drv_vec;
    to_regs = (e.req.adr >= regs_base) && (e.req.adr < regs_base + regs_bytes);
    // leaves the slice one edge later
    dep = cyc + 1;
    // the register block is busy right after a write, one extra edge
    if (to_regs && regs_wr_edge == cyc) begin
      dep = cyc + 2;
    end
    if (to_regs && e.req.op == op_write) begin
      regs_wr_edge = dep;
    end
    e.due = 32'(dep + 1);
    exp_q.push_back(e);
  endfunction

  function automatic void check_response();
    vec_t e;
    logic last;
    if (exp_q.size() == 0) begin
      $display("a response arrived at %0t ns with no request outstanding", $time);
      n_errors++;
      return;
    end
    e = exp_q.pop_front();
    n_rsp++;
    n_checks++;
    assert (e.due == 32'(cyc)) else begin
      $display("[ERROR] %0t ns test %0d access %0d: response at edge %0d, expected %0d",
               $time, e.num, e.idx, cyc, e.due);
      test_errs++;
      n_errors++;
    end
    n_checks++;
    assert (rsp.err == e.exp_err) else begin
      $display("[ERROR] %0t ns test %0d access %0d: err %0b, expected %0b",
               $time, e.num, e.idx, rsp.err, e.exp_err);
      test_errs++;
      n_errors++;
    end
    if (e.chk) begin
      n_checks++;
      assert (rsp.rdt == e.exp_rdt) else begin
        $display("[ERROR] %0t ns test %0d access %0d: rdt %08h, expected %08h",
                 $time, e.num, e.idx, rsp.rdt, e.exp_rdt);
        test_errs++;
        n_errors++;
      end
    end
    // a test ends with its last access in the file
    if (int'(e.idx) == vecs.size() - 1) begin
      last = 1'b1;
    end else begin
      last = (vecs[e.idx + 1].num != e.num);
    end
    if (last) begin
      tests_run++;
      if (test_errs == 0) begin
        $display("test %0d passed", e.num);
      end else begin
        $display("test %0d failed with %0d errors", e.num, test_errs);
        tests_failed++;
      end
      test_errs = 0;
    end
  endfunction

  // sampled before the edge updates any register
  always @(posedge sub) begin
    cyc = cyc + 1;
    if (rst_n) begin
      if (rsp_vld) begin
        check_response();
      end
      if (req_vld && req_rdy) begin
        push_expected();
      end
    end
  end

  //////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////

  initial begin : stimulus
    int gap;
    req_vld      = 1'b0;
    req          = '0;
    drv_vec      = '0;
    cyc          = 0;
    regs_wr_edge = 0;
    void'($urandom(75817));
    load_vectors();
    wait (rst_n);
    @(negedge sub);
    foreach (vecs[k]) begin
      drive_request(vecs[k]);
      req_vld = 1'b0;
      if (k + 1 < vecs.size() && vecs[k + 1].num == back_to_back_test) begin
        gap = 0;
      end else begin
        gap = $urandom_range(0, 2);
      end
      repeat (gap) @(negedge sub);
    end
    wait (n_rsp == vecs.size());
    // room for a duplicate response to show up
    repeat (4) @(negedge sub);
    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, n_checks, n_errors);
    if (n_errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  // budget scales with the number of accesses
  initial begin : watchdog
    #1;
    repeat (vecs.size() * cycles_per_vec + cycles_per_vec) @(posedge sub);
    $display("timeout: only %0d of %0d responses arrived in time", n_rsp, vecs.size());
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

/* test/tcb_clock_gen.sv */
// clock and reset source for the subsystem testbench
// 40 ns clock period, reset held low for the first 3 rising edges
// and released on a falling edge

`timescale 1ns/1ps

module tcb_clock_gen (
  output logic sub,
  output logic rst_n
);

  // half of the 40 ns period
  localparam int half_period_ns = 20;

  initial begin
    sub = 1'b0;
    forever #half_period_ns sub = ~sub;
  end

  // release away from the rising edge
  initial begin
    rst_n = 1'b0;
    repeat (3) @(posedge sub);
    @(negedge sub);
    rst_n = 1'b1;
  end

endmodule

/* logic/tcb_subsystem.sv */
// top level of the bus subsystem
// request goes through the register slice, then the address demux
// into the sram or the status registers
// their responses are merged back by the response mux, two cycles
// after the request transfer when the slice is not stalled

`timescale 1ns/1ps

module tcb_subsystem import tcb_pkg::*; (
  input  logic     sub,
  input  logic     rst_n,
  input  logic     req_vld,
  input  tcb_req_t req,
  output logic     req_rdy,
  output logic     rsp_vld,
  output tcb_rsp_t rsp
);

  // slice output
  logic        slc_vld;
  tcb_req_t    slc_req;
  logic        slc_rdy;
  // target handshakes
  logic        sram_vld;
  logic        sram_rdy;
  logic        regs_vld;
  logic        regs_rdy;
  // response path
  logic        rsp_stb;
  tcb_target_e rsp_tgt;
  tcb_rsp_t    sram_rsp;
  tcb_rsp_t    regs_rsp;

  tcb_register_request tcb_register_request_i (
    .sub     (sub),
    .rst_n   (rst_n),
    .in_vld  (req_vld),
    .in_req  (req),
    .in_rdy  (req_rdy),
    .out_vld (slc_vld),
    .out_req (slc_req),
    .out_rdy (slc_rdy)
  );

  tcb_address_demux tcb_address_demux_i (
    .sub      (sub),
    .rst_n    (rst_n),
    .in_vld   (slc_vld),
    .in_req   (slc_req),
    .in_rdy   (slc_rdy),
    .sram_vld (sram_vld),
    .sram_rdy (sram_rdy),
    .regs_vld (regs_vld),
    .regs_rdy (regs_rdy),
    .rsp_stb  (rsp_stb),
    .rsp_tgt  (rsp_tgt)
  );

  // both targets see the same request fields
  tcb_sram tcb_sram_i (
    .sub (sub),
    .vld (sram_vld),
    .rdy (sram_rdy),
    .req (slc_req),
    .rsp (sram_rsp)
  );

  tcb_status_regs tcb_status_regs_i (
    .sub   (sub),
    .rst_n (rst_n),
    .vld   (regs_vld),
    .rdy   (regs_rdy),
    .req   (slc_req),
    .rsp   (regs_rsp)
  );

  tcb_response_mux tcb_response_mux_i (
    .rsp_stb  (rsp_stb),
    .rsp_tgt  (rsp_tgt),
    .sram_rsp (sram_rsp),
    .regs_rsp (regs_rsp),
    .rsp_vld  (rsp_vld),
    .rsp      (rsp)
  );

endmodule

/* logic/tcb_response_mux.sv */
// response multiplexer
// forwards the response of the target that took the request and
// answers unmapped requests with an error and zero read data
// purely combinational, the strobe becomes the response valid

`timescale 1ns/1ps

module tcb_response_mux import tcb_pkg::*; (
  input  logic        rsp_stb,
  input  tcb_target_e rsp_tgt,
  input  tcb_rsp_t    sram_rsp,
  input  tcb_rsp_t    regs_rsp,
  output logic        rsp_vld,
  output tcb_rsp_t    rsp
);

  //////////////////////////////////////////////////
  // response select
  //////////////////////////////////////////////////

  // one response per transfer, no back-pressure
  assign rsp_vld = rsp_stb;

  always_comb begin
    unique case (rsp_tgt)
      tgt_sram: rsp = sram_rsp;
      tgt_regs: rsp = regs_rsp;
      default: begin
        // decode miss
        rsp.rdt = '0;
        rsp.err = 1'b1;
      end
    endcase
  end

endmodule

/* logic/tcb_status_regs.sv */
// status register block subordinate
// offset 0 identity, read only
// offset 1 scratch, read and write with byte enables
// offset 2 write counter, read only, counts successful writes here
// bad writes and reads of the unused offset answer with err
// ready drops for one cycle after every accepted write

`timescale 1ns/1ps

module tcb_status_regs import tcb_pkg::*; (
  input  logic     sub,
  input  logic     rst_n,
  input  logic     vld,
  output logic     rdy,
  input  tcb_req_t req,
  output tcb_rsp_t rsp
);

  logic [reg_ofs_w-1:0] ofs;
  logic                 xfer;
  logic                 busy;
  logic                 wr_ok;
  logic [dat_w-1:0]     scratch;
  logic [dat_w-1:0]     count;
  logic [dat_w-1:0]     rd_dat;
  logic                 acc_err;
  logic [dat_w-1:0]     rdt_q;
  logic                 err_q;

  assign ofs  = req.adr[regs_adr_w-1:2];
  assign rdy  = ~busy;
  assign xfer = vld & rdy;

  //////////////////////////////////////////////////
  // access decode
  //////////////////////////////////////////////////

  always_comb begin
    rd_dat  = '0;
    acc_err = 1'b0;
    if (req.op == op_write) begin
      // only scratch takes writes
      acc_err = (ofs != reg_scratch_ofs);
    end else begin
      unique case (ofs)
        reg_id_ofs:      rd_dat = reg_id_value;
        reg_scratch_ofs: rd_dat = scratch;
        reg_count_ofs:   rd_dat = count;
        default:         acc_err = 1'b1;
      endcase
    end
  end

  // a write that lands and changes state
  assign wr_ok = xfer && (req.op == op_write) && !acc_err;

  //////////////////////////////////////////////////
  // registers
  //////////////////////////////////////////////////

  always_ff @(posedge sub) begin
    if (!rst_n) begin
      busy    <= 1'b0;
      scratch <= '0;
      count   <= '0;
    end else begin
      // one idle cycle after any accepted write, failed or not
      busy <= xfer && (req.op == op_write);
      if (wr_ok) begin
        scratch <= ben_merge(scratch, req.wdt, req.ben);
        count   <= count + 1'b1;
      end
    end
  end

  // response captured at the transfer
  always_ff @(posedge sub) begin
    if (xfer) begin
      rdt_q <= rd_dat;
      err_q <= acc_err;
    end
  end

  assign rsp.rdt = rdt_q;
  assign rsp.err = err_q;

  // the cycle after an accepted write never carries a transfer
  a_busy_stall: assert property (
    @(posedge sub) disable iff (!rst_n)
    (xfer && (req.op == op_write)) |=> !(vld && rdy)
  );

endmodule

/* logic/tcb_sram.sv */
// word sram subordinate
// always ready, writes bytes under the byte enables and returns the
// addressed word one cycle after every transfer
// read data of a write transfer is the word as it was before the write

`timescale 1ns/1ps

module tcb_sram import tcb_pkg::*; (
  input  logic     sub,
  input  logic     vld,
  output logic     rdy,
  input  tcb_req_t req,
  output tcb_rsp_t rsp
);

  localparam int idx_w = $clog2(sram_words);

  logic [dat_w-1:0] mem [sram_words];
  logic [idx_w-1:0] idx;
  logic [dat_w-1:0] rdt_q;

  // never back-pressures the bus
  assign rdy = 1'b1;

  // word index, low two bits select a byte and are dropped
  assign idx = req.adr[sram_adr_w-1:2];

  //////////////////////////////////////////////////
  // memory array
  //////////////////////////////////////////////////

  // byte enabled write
  always_ff @(posedge sub) begin
    if (vld && rdy && (req.op == op_write)) begin
      mem[idx] <= ben_merge(mem[idx], req.wdt, req.ben);
    end
  end

  // read data registered on every transfer
  always_ff @(posedge sub) begin
    if (vld && rdy) begin
      rdt_q <= mem[idx];
    end
  end

  //////////////////////////////////////////////////
  // response
  //////////////////////////////////////////////////

  // the sram has no error condition
  assign rsp.rdt = rdt_q;
  assign rsp.err = 1'b0;

endmodule

/* logic/tcb_address_demux.sv */
// address demultiplexer for the subsystem
// decodes the request address against the map, steers valid to the
// sram or the register block, and absorbs unmapped requests itself
// the chosen target is kept for the response cycle so the response
// multiplexer knows whose answer to forward

`timescale 1ns/1ps

module tcb_address_demux import tcb_pkg::*; (
  input  logic        sub,
  input  logic        rst_n,
  // upstream request
  input  logic        in_vld,
  input  tcb_req_t    in_req,
  output logic        in_rdy,
  // sram target
  output logic        sram_vld,
  input  logic        sram_rdy,
  // register block target
  output logic        regs_vld,
  input  logic        regs_rdy,
  // response cycle info
  output logic        rsp_stb,
  output tcb_target_e rsp_tgt
);

  tcb_target_e tgt;
  logic        xfer;

  //////////////////////////////////////////////////
  // address decode
  //////////////////////////////////////////////////

  always_comb begin
    if (in_req.adr[adr_w-1:sram_adr_w] == '0) begin
      tgt = tgt_sram;
    end else if (in_req.adr[adr_w-1:regs_adr_w] == regs_base[adr_w-1:regs_adr_w]) begin
      tgt = tgt_regs;
    end else begin
      tgt = tgt_none;
    end
  end

  // valid goes to one target only
  assign sram_vld = in_vld && (tgt == tgt_sram);
  assign regs_vld = in_vld && (tgt == tgt_regs);

  // ready comes back from the chosen target
  always_comb begin
    unique case (tgt)
      tgt_sram: in_rdy = sram_rdy;
      tgt_regs: in_rdy = regs_rdy;
      // unmapped requests are never stalled
      default:  in_rdy = 1'b1;
    endcase
  end

  assign xfer = in_vld & in_rdy;

  //////////////////////////////////////////////////
  // response cycle tracking
  //////////////////////////////////////////////////

  // strobe and target line up with the subordinate response
  always_ff @(posedge sub) begin
    if (!rst_n) begin
      rsp_stb <= 1'b0;
      rsp_tgt <= tgt_none;
    end else begin
      rsp_stb <= xfer;
      if (xfer) begin
        rsp_tgt <= tgt;
      end
    end
  end

  a_one_target: assert property (
    @(posedge sub) disable iff (!rst_n)
    !(sram_vld && regs_vld)
  );

endmodule

/* logic/tcb_register_request.sv */
// request path register slice
// cuts the combinational path on valid and on the request fields,
// ready stays high while the output stage is empty so no bubbles
// appear in a stream of back to back requests

`timescale 1ns/1ps

module tcb_register_request import tcb_pkg::*; (
  input  logic     sub,
  input  logic     rst_n,
  // upstream side, manager connects here
  input  logic     in_vld,
  input  tcb_req_t in_req,
  output logic     in_rdy,
  // downstream side, subordinate connects here
  output logic     out_vld,
  output tcb_req_t out_req,
  input  logic     out_rdy
);

  //////////////////////////////////////////////////
  // handshake
  //////////////////////////////////////////////////

  // accept when the output moves on or holds nothing
  assign in_rdy = out_rdy | ~out_vld;

  always_ff @(posedge sub) begin
    if (!rst_n) begin
      out_vld <= 1'b0;
    end else if (in_rdy) begin
      out_vld <= in_vld;
    end
  end

  //////////////////////////////////////////////////
  // request payload
  //////////////////////////////////////////////////

  // payload follows the same load condition as valid
  always_ff @(posedge sub) begin
    if (in_rdy) begin
      out_req <= in_req;
    end
  end

  // a stalled output must not change until it is taken
  a_out_hold: assert property (
    @(posedge sub) disable iff (!rst_n)
    (out_vld && !out_rdy) |=> (out_vld && $stable(out_req))
  );

endmodule

/* logic/tcb_pkg.sv */
// shared definitions for the tightly coupled bus subsystem
// holds the bus widths, the address map, the request and response
// structs and the opcode and target enums
// every module of the subsystem takes it with a wildcard import

package tcb_pkg;

  //////////////////////////////////////////////////
  // bus widths
  //////////////////////////////////////////////////

  // byte address, data and byte enable widths
  localparam int adr_w = 12;
  localparam int dat_w = 32;
  localparam int ben_w = 4;

  //////////////////////////////////////////////////
  // address map
  //////////////////////////////////////////////////

  // sram depth in words, occupies byte addresses 0x000 to 0x3ff
  localparam int sram_words = 256;
  // byte address bits covered by the sram
  localparam int sram_adr_w = $clog2(sram_words) + 2;

  // register block base and word offsets inside it
  localparam logic [adr_w-1:0] regs_base = 12'h800;
  localparam int reg_ofs_w = 2;
  // byte address bits covered by the register block (4 words)
  localparam int regs_adr_w = reg_ofs_w + 2;
  localparam logic [reg_ofs_w-1:0] reg_id_ofs      = 2'd0;
  localparam logic [reg_ofs_w-1:0] reg_scratch_ofs = 2'd1;
  localparam logic [reg_ofs_w-1:0] reg_count_ofs   = 2'd2;

  // identity register read back value
  localparam logic [dat_w-1:0] reg_id_value = 32'h7CB0_0001;

  //////////////////////////////////////////////////
  // types
  //////////////////////////////////////////////////

  typedef enum logic {
    op_read  = 1'b0,
    op_write = 1'b1
  } tcb_op_e;

  // address decode result
  typedef enum logic [1:0] {
    tgt_sram = 2'd0,
    tgt_regs = 2'd1,
    tgt_none = 2'd2
  } tcb_target_e;

  typedef struct packed {
    tcb_op_e          op;
    logic [adr_w-1:0] adr;
    logic [dat_w-1:0] wdt;
    logic [ben_w-1:0] ben;
  } tcb_req_t;

  typedef struct packed {
    logic [dat_w-1:0] rdt;
    logic             err;
  } tcb_rsp_t;

  // merge new write data into an old word under byte enables
  function automatic logic [dat_w-1:0] ben_merge(
    input logic [dat_w-1:0] old_dat,
    input logic [dat_w-1:0] new_dat,
    input logic [ben_w-1:0] ben
  );
    logic [dat_w-1:0] res;
    res = old_dat;
    for (int b = 0; b < ben_w; b++) begin
      if (ben[b]) res[8*b +: 8] = new_dat[8*b +: 8];
    end
    return res;
  endfunction

endpackage
